// ==== Makefile ====
# Verilator build and run for the CSR trap unit

VERILATOR ?= verilator
TOP       ?= csr_trap_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation finished without failures"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+include
hw/csr_pkg.sv
hw/pipe_pkg.sv
hw/csr_wdata_unit.sv
hw/trap_ctrl.sv
hw/csr_regfile.sv
hw/csr_trap_unit.sv
tb/csr_trap_unit_checker.sv
tb/csr_trap_unit_tb.sv

// ==== hw/csr_pkg.sv ====
// Architectural CSR types
`default_nettype none

`include "csr_defs.svh"

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // Plain vectors
  ////////////////////////////////////////////////////////////

  typedef logic [`CSR_XLEN-1:0] csr_data_t;
  typedef logic [4:0]           cause_code_t;
  typedef logic [1:0]           priv_lvl_t;
  typedef logic [2:0]           dbg_cause_t;

  // Implemented CSR addresses, anything else reads as zero
  typedef enum logic [11:0] {
    CSR_MSTATUS   = `CSR_ADDR_MSTATUS,
    CSR_MIE       = `CSR_ADDR_MIE,
    CSR_MTVEC     = `CSR_ADDR_MTVEC,
    CSR_MSCRATCH  = `CSR_ADDR_MSCRATCH,
    CSR_MEPC      = `CSR_ADDR_MEPC,
    CSR_MCAUSE    = `CSR_ADDR_MCAUSE,
    CSR_MIP       = `CSR_ADDR_MIP,
    CSR_DCSR      = `CSR_ADDR_DCSR,
    CSR_DPC       = `CSR_ADDR_DPC,
    CSR_DSCRATCH0 = `CSR_ADDR_DSCRATCH0
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////////////////////////
  // Register layouts
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [18:0] rsvd_31_13;
    priv_lvl_t   mpp;
    logic [2:0]  rsvd_10_8;
    logic        mpie;
    logic [2:0]  rsvd_6_4;
    logic        mie;
    logic [2:0]  rsvd_2_0;
  } mstatus_t;

  typedef struct packed {
    logic        irq;
    logic [25:0] rsvd_30_5;
    cause_code_t code;
  } mcause_t;

  // Debug control and status, only cause and prv carry state here
  typedef struct packed {
    logic [3:0]  xdebugver;
    logic [18:0] rsvd_27_9;
    dbg_cause_t  cause;
    logic [3:0]  rsvd_5_2;
    priv_lvl_t   prv;
  } dcsr_t;

endpackage

`default_nettype wire

// ==== hw/csr_regfile.sv ====
// Machine-mode CSR file
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_regfile (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  pipe_pkg::ex_wb_pipe_t wb_instr_i,
  input  pipe_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  logic                  irq_i,
  input  csr_pkg::csr_data_t    new_i,
  input  logic                  wr_en_i,
  output csr_pkg::csr_data_t    old_o,
  output csr_pkg::csr_data_t    rdata_o,
  output csr_pkg::mstatus_t     mstatus_o,
  output logic                  meie_o,
  output csr_pkg::csr_data_t    mepc_o,
  output csr_pkg::csr_data_t    dpc_o,
  output csr_pkg::csr_data_t    mtvec_o
);

  csr_pkg::mstatus_t  mstatus_q;
  csr_pkg::csr_data_t mie_q;
  csr_pkg::csr_data_t mtvec_q;
  csr_pkg::csr_data_t mscratch_q;
  csr_pkg::csr_data_t mepc_q;
  csr_pkg::mcause_t   mcause_q;
  csr_pkg::dcsr_t     dcsr_q;
  csr_pkg::csr_data_t dpc_q;
  csr_pkg::csr_data_t dscratch0_q;
  csr_pkg::csr_data_t mip;
  csr_pkg::csr_data_t rdata;
  logic               sw_we;

  // Pending external interrupt is the only source in mip
  always_comb begin
    mip               = '0;
    mip[`CSR_MEI_BIT] = irq_i;
  end

  ////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_instr_i.csr_addr)
      csr_pkg::CSR_MSTATUS:   rdata = mstatus_q;
      csr_pkg::CSR_MIE:       rdata = mie_q;
      csr_pkg::CSR_MTVEC:     rdata = mtvec_q;
      csr_pkg::CSR_MSCRATCH:  rdata = mscratch_q;
      csr_pkg::CSR_MEPC:      rdata = mepc_q;
      csr_pkg::CSR_MCAUSE:    rdata = mcause_q;
      csr_pkg::CSR_MIP:       rdata = mip;
      csr_pkg::CSR_DCSR:      rdata = dcsr_q;
      csr_pkg::CSR_DPC:       rdata = dpc_q;
      csr_pkg::CSR_DSCRATCH0: rdata = dscratch0_q;
      default:                rdata = '0;
    endcase
  end

  assign old_o   = rdata;
  assign rdata_o = rdata;

  // A killed or halted instruction must not reach the registers
  assign sw_we = wb_instr_i.instr_valid && wb_instr_i.csr_en && wr_en_i &&
                 !ctrl_fsm_i.kill_wb && !ctrl_fsm_i.halt_wb;

  ////////////////////////////////////////////////////////////
  // Register update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mstatus_q           <= '0;
      mstatus_q.mpp       <= `CSR_PRIV_M;
      mie_q               <= '0;
      mtvec_q             <= `CSR_MTVEC_RST;
      mscratch_q          <= '0;
      mepc_q              <= '0;
      mcause_q            <= '0;
      dcsr_q              <= '0;
      dcsr_q.xdebugver    <= `CSR_DEBUGVER;
      dcsr_q.prv          <= `CSR_PRIV_M;
      dpc_q               <= '0;
      dscratch0_q         <= '0;
    end else begin
      if (sw_we) begin
        case (wb_instr_i.csr_addr)
          csr_pkg::CSR_MSTATUS:   mstatus_q   <= csr_pkg::mstatus_t'(new_i);
          csr_pkg::CSR_MIE:       mie_q       <= new_i;
          csr_pkg::CSR_MTVEC:     mtvec_q     <= new_i;
          csr_pkg::CSR_MSCRATCH:  mscratch_q  <= new_i;
          csr_pkg::CSR_MEPC:      mepc_q      <= new_i;
          csr_pkg::CSR_MCAUSE:    mcause_q    <= csr_pkg::mcause_t'(new_i);
          csr_pkg::CSR_DCSR:      dcsr_q      <= csr_pkg::dcsr_t'(new_i);
          csr_pkg::CSR_DPC:       dpc_q       <= new_i;
          csr_pkg::CSR_DSCRATCH0: dscratch0_q <= new_i;
          default: ;
        endcase
      end
      // Controller updates come last so they override the software write
      if (ctrl_fsm_i.csr_save_cause) begin
        mepc_q         <= ctrl_fsm_i.pipe_pc;
        mcause_q       <= ctrl_fsm_i.csr_cause;
        mstatus_q.mpie <= mstatus_q.mie;
        mstatus_q.mie  <= 1'b0;
      end
      if (ctrl_fsm_i.csr_restore_mret) begin
        mstatus_q.mie  <= mstatus_q.mpie;
        mstatus_q.mpie <= 1'b1;
      end
      if (ctrl_fsm_i.debug_csr_save) begin
        dpc_q        <= ctrl_fsm_i.pipe_pc;
        dcsr_q.cause <= 3'd3;
      end
    end
  end

  assign mstatus_o = mstatus_q;
  assign meie_o    = mie_q[`CSR_MEI_BIT];
  assign mepc_o    = mepc_q;
  assign dpc_o     = dpc_q;
  assign mtvec_o   = mtvec_q;

endmodule

`default_nettype wire

// ==== hw/csr_trap_unit.sv ====
// CSR and trap unit top
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  pipe_pkg::ex_wb_pipe_t wb_instr_i,
  input  logic                  irq_i,
  input  logic                  debug_req_i,
  output csr_pkg::csr_data_t    csr_rdata_o,
  output logic                  branch_o,
  output csr_pkg::csr_data_t    branch_addr_o,
  output logic                  debug_mode_o
);

  pipe_pkg::ctrl_fsm_t ctrl_fsm;
  csr_pkg::mstatus_t   mstatus_q;
  logic                mie_meie;
  csr_pkg::csr_data_t  mepc_q;
  csr_pkg::csr_data_t  dpc_q;
  csr_pkg::csr_data_t  mtvec_q;
  csr_pkg::csr_data_t  old_value;
  csr_pkg::csr_data_t  new_value;
  logic                wr_en;

  trap_ctrl u_trap_ctrl (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .wb_instr_i    (wb_instr_i),
    .irq_i         (irq_i),
    .debug_req_i   (debug_req_i),
    .mstatus_i     (mstatus_q),
    .meie_i        (mie_meie),
    .mepc_i        (mepc_q),
    .dpc_i         (dpc_q),
    .mtvec_i       (mtvec_q),
    .ctrl_fsm_o    (ctrl_fsm),
    .branch_o      (branch_o),
    .branch_addr_o (branch_addr_o),
    .debug_mode_o  (debug_mode_o)
  );

  csr_wdata_unit u_csr_wdata_unit (
    .op_i      (wb_instr_i.csr_op),
    .operand_i (wb_instr_i.csr_wdata),
    .old_i     (old_value),
    .addr_i    (wb_instr_i.csr_addr),
    .new_o     (new_value),
    .wr_en_o   (wr_en)
  );

  csr_regfile u_csr_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_instr_i (wb_instr_i),
    .ctrl_fsm_i (ctrl_fsm),
    .irq_i      (irq_i),
    .new_i      (new_value),
    .wr_en_i    (wr_en),
    .old_o      (old_value),
    .rdata_o    (csr_rdata_o),
    .mstatus_o  (mstatus_q),
    .meie_o     (mie_meie),
    .mepc_o     (mepc_q),
    .dpc_o      (dpc_q),
    .mtvec_o    (mtvec_q)
  );

endmodule

`default_nettype wire

// ==== hw/csr_wdata_unit.sv ====
// CSR write data and WARL masking
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_wdata_unit (
  input  csr_pkg::csr_op_e   op_i,
  input  csr_pkg::csr_data_t operand_i,
  input  csr_pkg::csr_data_t old_i,
  input  csr_pkg::csr_num_e  addr_i,
  output csr_pkg::csr_data_t new_o,
  output logic               wr_en_o
);

  csr_pkg::csr_data_t raw_value;

  // Replace, OR or AND-NOT against the current contents
  always_comb begin
    case (op_i)
      csr_pkg::CSR_OP_WRITE: raw_value = operand_i;
      csr_pkg::CSR_OP_SET:   raw_value = old_i | operand_i;
      csr_pkg::CSR_OP_CLEAR: raw_value = old_i & ~operand_i;
      default:               raw_value = old_i;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Legal values per register
  ////////////////////////////////////////////////////////////

  always_comb begin
    csr_pkg::mstatus_t raw_st;
    csr_pkg::mstatus_t new_st;
    csr_pkg::mcause_t  raw_mc;
    csr_pkg::mcause_t  new_mc;
    raw_st = csr_pkg::mstatus_t'(raw_value);
    raw_mc = csr_pkg::mcause_t'(raw_value);
    new_st = '0;
    new_mc = '0;
    new_o  = raw_value;
    case (addr_i)
      csr_pkg::CSR_MTVEC: begin
        // Direct mode only, base is word aligned
        new_o = {raw_value[`CSR_XLEN-1:2], 2'b00};
      end
      csr_pkg::CSR_MEPC, csr_pkg::CSR_DPC: begin
        new_o = {raw_value[`CSR_XLEN-1:1], 1'b0};
      end
      csr_pkg::CSR_MSTATUS: begin
        new_st.mie  = raw_st.mie;
        new_st.mpie = raw_st.mpie;
        new_st.mpp  = `CSR_PRIV_M;
        new_o       = new_st;
      end
      csr_pkg::CSR_MIE: begin
        new_o              = '0;
        new_o[`CSR_MEI_BIT] = raw_value[`CSR_MEI_BIT];
      end
      csr_pkg::CSR_MCAUSE: begin
        new_mc.irq  = raw_mc.irq;
        new_mc.code = raw_mc.code;
        new_o       = new_mc;
      end
      default: new_o = raw_value;
    endcase
  end

  // Set and clear with a zero operand are reads
  assign wr_en_o = (op_i == csr_pkg::CSR_OP_WRITE) ||
                   (((op_i == csr_pkg::CSR_OP_SET) || (op_i == csr_pkg::CSR_OP_CLEAR)) &&
                    (|operand_i));

endmodule

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
// Pipeline and controller types
`default_nettype none

package pipe_pkg;

  // Instruction retiring in write-back
  typedef struct packed {
    logic                 instr_valid;
    logic                 csr_en;
    csr_pkg::csr_op_e     csr_op;
    csr_pkg::csr_num_e    csr_addr;
    csr_pkg::csr_data_t   csr_wdata;
    csr_pkg::csr_data_t   pc;
    logic                 exc;
    csr_pkg::cause_code_t exc_code;
    logic                 mret;
    logic                 dret;
  } ex_wb_pipe_t;

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FUNCTIONAL  = 2'b00,
    DEBUG_TAKEN = 2'b01,
    DEBUG_MODE  = 2'b10
  } ctrl_state_e;

  // Commands from the controller to the register file
  typedef struct packed {
    logic               kill_wb;
    logic               halt_wb;
    logic               csr_save_cause;
    logic               debug_csr_save;
    logic               csr_restore_mret;
    logic               csr_restore_dret;
    csr_pkg::mcause_t   csr_cause;
    csr_pkg::csr_data_t pipe_pc;
  } ctrl_fsm_t;

endpackage

`default_nettype wire

// ==== hw/trap_ctrl.sv ====
// Trap and debug controller
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module trap_ctrl (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  pipe_pkg::ex_wb_pipe_t wb_instr_i,
  input  logic                  irq_i,
  input  logic                  debug_req_i,
  input  csr_pkg::mstatus_t     mstatus_i,
  input  logic                  meie_i,
  input  csr_pkg::csr_data_t    mepc_i,
  input  csr_pkg::csr_data_t    dpc_i,
  input  csr_pkg::csr_data_t    mtvec_i,
  output pipe_pkg::ctrl_fsm_t   ctrl_fsm_o,
  output logic                  branch_o,
  output csr_pkg::csr_data_t    branch_addr_o,
  output logic                  debug_mode_o
);

  pipe_pkg::ctrl_state_e state_q;
  pipe_pkg::ctrl_state_e state_n;
  logic                  branch_q;
  csr_pkg::csr_data_t    branch_addr_q;
  csr_pkg::csr_data_t    branch_target;
  logic                  evt_valid;
  logic                  debug_evt;
  logic                  irq_evt;
  logic                  exc_evt;
  logic                  mret_evt;
  logic                  dret_evt;
  logic                  any_evt;

  // Nothing in write-back counts during the redirect cycle
  assign evt_valid = wb_instr_i.instr_valid && !branch_q;

  ////////////////////////////////////////////////////////////
  // Event selection and next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    debug_evt = 1'b0;
    irq_evt   = 1'b0;
    exc_evt   = 1'b0;
    mret_evt  = 1'b0;
    dret_evt  = 1'b0;
    state_n   = state_q;
    case (state_q)
      pipe_pkg::FUNCTIONAL: begin
        if (evt_valid) begin
          if (debug_req_i) begin
            debug_evt = 1'b1;
            state_n   = pipe_pkg::DEBUG_TAKEN;
          end else if (irq_i && mstatus_i.mie && meie_i) begin
            irq_evt = 1'b1;
          end else if (wb_instr_i.exc) begin
            exc_evt = 1'b1;
          end else if (wb_instr_i.mret) begin
            mret_evt = 1'b1;
          end
        end
      end
      pipe_pkg::DEBUG_TAKEN: state_n = pipe_pkg::DEBUG_MODE;
      pipe_pkg::DEBUG_MODE: begin
        // Only dret leaves debug mode
        if (evt_valid && wb_instr_i.dret) begin
          dret_evt = 1'b1;
          state_n  = pipe_pkg::FUNCTIONAL;
        end
      end
      default: state_n = pipe_pkg::FUNCTIONAL;
    endcase
  end

  assign any_evt = debug_evt | irq_evt | exc_evt | mret_evt | dret_evt;

  always_comb begin
    if (debug_evt) begin
      branch_target = `CSR_DM_HALT_ADDR;
    end else if (dret_evt) begin
      branch_target = dpc_i;
    end else if (mret_evt) begin
      branch_target = mepc_i;
    end else begin
      branch_target = {mtvec_i[`CSR_XLEN-1:2], 2'b00};
    end
  end

  // Commands to the register file
  always_comb begin
    ctrl_fsm_o                  = '0;
    ctrl_fsm_o.kill_wb          = debug_evt | irq_evt | exc_evt;
    ctrl_fsm_o.halt_wb          = branch_q;
    ctrl_fsm_o.csr_save_cause   = irq_evt | exc_evt;
    ctrl_fsm_o.debug_csr_save   = debug_evt;
    ctrl_fsm_o.csr_restore_mret = mret_evt;
    ctrl_fsm_o.csr_restore_dret = dret_evt;
    ctrl_fsm_o.pipe_pc          = wb_instr_i.pc;
    if (irq_evt) begin
      ctrl_fsm_o.csr_cause.irq  = 1'b1;
      ctrl_fsm_o.csr_cause.code = 5'(`CSR_MEI_BIT);
    end else if (exc_evt) begin
      ctrl_fsm_o.csr_cause.code = wb_instr_i.exc_code;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q  <= pipe_pkg::FUNCTIONAL;
      branch_q <= 1'b0;
    end else begin
      state_q  <= state_n;
      branch_q <= any_evt;
    end
  end

  // Target only matters while branch_q is high
  always_ff @(posedge clk) begin
    if (any_evt) begin
      branch_addr_q <= branch_target;
    end
  end

  assign branch_o      = branch_q;
  assign branch_addr_o = branch_addr_q;
  assign debug_mode_o  = (state_q != pipe_pkg::FUNCTIONAL);

endmodule

`default_nettype wire

// ==== include/csr_defs.svh ====
// CSR unit definitions
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data path width
`define CSR_XLEN            32

// Machine-mode and debug CSR addresses
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_DCSR       12'h7B0
`define CSR_ADDR_DPC        12'h7B1
`define CSR_ADDR_DSCRATCH0  12'h7B2

// Reset values, fixed fields and redirect targets
`define CSR_MTVEC_RST       32'h0000_0100
`define CSR_DM_HALT_ADDR    32'h1A11_0800
`define CSR_PRIV_M          2'b11
`define CSR_DEBUGVER        4'd4
`define CSR_MEI_BIT         11

`endif

// ==== tb/csr_trap_unit_checker.sv ====
// CSR trap unit assertions
`timescale 1ns/1ps
`default_nettype none

module csr_trap_unit_checker (
  input logic                  clk,
  input logic                  rst_n_i,
  input pipe_pkg::ex_wb_pipe_t wb_instr_i,
  input pipe_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input pipe_pkg::ctrl_state_e state_i,
  input csr_pkg::csr_data_t    mscratch_i,
  input csr_pkg::csr_data_t    mepc_i,
  input csr_pkg::csr_data_t    dpc_i
);

  logic zero_op;
  logic wb_blocked;

  // Set or clear with nothing to change
  assign zero_op = wb_instr_i.instr_valid && wb_instr_i.csr_en &&
                   ((wb_instr_i.csr_op == csr_pkg::CSR_OP_SET) ||
                    (wb_instr_i.csr_op == csr_pkg::CSR_OP_CLEAR)) &&
                   (wb_instr_i.csr_wdata == '0);

  assign wb_blocked = ctrl_fsm_i.kill_wb || ctrl_fsm_i.halt_wb;

  ////////////////////////////////////////////////////////////
  // Write suppression
  ////////////////////////////////////////////////////////////

  a_scratch_kept: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_blocked && wb_instr_i.csr_en && wb_instr_i.csr_addr == csr_pkg::CSR_MSCRATCH)
    |=> $stable(mscratch_i))
    else $error("mscratch changed by a blocked instruction");

  a_zero_op_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (zero_op && wb_instr_i.csr_addr == csr_pkg::CSR_MSCRATCH) |=> $stable(mscratch_i))
    else $error("zero-operand set or clear changed mscratch");

  ////////////////////////////////////////////////////////////
  // Controller commands
  ////////////////////////////////////////////////////////////

  a_cmd_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({ctrl_fsm_i.csr_save_cause, ctrl_fsm_i.debug_csr_save,
              ctrl_fsm_i.csr_restore_mret, ctrl_fsm_i.csr_restore_dret}))
    else $error("more than one save or restore command in a cycle");

  a_trap_mepc: assert property (@(posedge clk) disable iff (!rst_n_i)
    ctrl_fsm_i.csr_save_cause |=> (mepc_i == $past(ctrl_fsm_i.pipe_pc)))
    else $error("mepc does not hold the trapped pc");

  a_debug_entry: assert property (@(posedge clk) disable iff (!rst_n_i)
    ctrl_fsm_i.debug_csr_save |=>
      (state_i == pipe_pkg::DEBUG_TAKEN) && ctrl_fsm_i.halt_wb &&
      (dpc_i == $past(ctrl_fsm_i.pipe_pc)))
    else $error("debug entry did not reach DEBUG_TAKEN with halt and dpc");

endmodule

bind csr_trap_unit csr_trap_unit_checker u_checker (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .wb_instr_i (wb_instr_i),
  .ctrl_fsm_i (ctrl_fsm),
  .state_i    (u_trap_ctrl.state_q),
  .mscratch_i (u_csr_regfile.mscratch_q),
  .mepc_i     (mepc_q),
  .dpc_i      (dpc_q)
);

`default_nettype wire

// ==== tb/csr_trap_unit_tb.sv ====
// CSR trap unit testbench
`timescale 1ns/1ps
`default_nettype none

`include "csr_defs.svh"

module csr_trap_unit_tb;

  localparam int TIMEOUT_CYCLES = 20;
  localparam int N_RANDOM       = 60;

  logic                  clk;
  logic                  rst_n_i;
  pipe_pkg::ex_wb_pipe_t wb_instr;
  logic                  irq;
  logic                  debug_req;
  csr_pkg::csr_data_t    csr_rdata;
  logic                  branch;
  csr_pkg::csr_data_t    branch_addr;
  logic                  debug_mode;

  // Levels applied to irq_i and debug_req_i with the next instruction
  logic irq_lvl;
  logic dbg_lvl;

  // Shadow copy of every CSR
  csr_pkg::csr_data_t sh_mstatus;
  csr_pkg::csr_data_t sh_mie;
  csr_pkg::csr_data_t sh_mtvec;
  csr_pkg::csr_data_t sh_mscratch;
  csr_pkg::csr_data_t sh_mepc;
  csr_pkg::csr_data_t sh_mcause;
  csr_pkg::csr_data_t sh_dcsr;
  csr_pkg::csr_data_t sh_dpc;
  csr_pkg::csr_data_t sh_dscratch0;
  logic               in_debug;
  csr_pkg::csr_data_t next_pc;

  int errors;
  int err_mark;
  int tests_run;
  int tests_failed;

  csr_pkg::csr_num_e rw_addrs [9] = '{
    csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC, csr_pkg::CSR_MSCRATCH,
    csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_DCSR, csr_pkg::CSR_DPC,
    csr_pkg::CSR_DSCRATCH0
  };

  csr_trap_unit dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .wb_instr_i    (wb_instr),
    .irq_i         (irq),
    .debug_req_i   (debug_req),
    .csr_rdata_o   (csr_rdata),
    .branch_o      (branch),
    .branch_addr_o (branch_addr),
    .debug_mode_o  (debug_mode)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic csr_pkg::csr_data_t legalize(input csr_pkg::csr_num_e addr,
                                                  input csr_pkg::csr_data_t v);
    case (addr)
      csr_pkg::CSR_MTVEC:                  return v & 32'hFFFF_FFFC;
      csr_pkg::CSR_MEPC, csr_pkg::CSR_DPC: return v & 32'hFFFF_FFFE;
      // Bits 3 and 7 are writable, bits 12:11 read as machine mode
      csr_pkg::CSR_MSTATUS:                return (v & 32'h0000_0088) | 32'h0000_1800;
      csr_pkg::CSR_MIE:                    return v & 32'h0000_0800;
      csr_pkg::CSR_MCAUSE:                 return v & 32'h8000_001F;
      default:                             return v;
    endcase
  endfunction

  function automatic csr_pkg::csr_data_t shadow_read(input csr_pkg::csr_num_e addr);
    case (addr)
      csr_pkg::CSR_MSTATUS:   return sh_mstatus;
      csr_pkg::CSR_MIE:       return sh_mie;
      csr_pkg::CSR_MTVEC:     return sh_mtvec;
      csr_pkg::CSR_MSCRATCH:  return sh_mscratch;
      csr_pkg::CSR_MEPC:      return sh_mepc;
      csr_pkg::CSR_MCAUSE:    return sh_mcause;
      csr_pkg::CSR_MIP:       return {20'd0, irq, 11'd0};
      csr_pkg::CSR_DCSR:      return sh_dcsr;
      csr_pkg::CSR_DPC:       return sh_dpc;
      csr_pkg::CSR_DSCRATCH0: return sh_dscratch0;
      default:                return '0;
    endcase
  endfunction

  task automatic shadow_write(input csr_pkg::csr_num_e addr, input csr_pkg::csr_data_t v);
    case (addr)
      csr_pkg::CSR_MSTATUS:   sh_mstatus   = v;
      csr_pkg::CSR_MIE:       sh_mie       = v;
      csr_pkg::CSR_MTVEC:     sh_mtvec     = v;
      csr_pkg::CSR_MSCRATCH:  sh_mscratch  = v;
      csr_pkg::CSR_MEPC:      sh_mepc      = v;
      csr_pkg::CSR_MCAUSE:    sh_mcause    = v;
      csr_pkg::CSR_DCSR:      sh_dcsr      = v;
      csr_pkg::CSR_DPC:       sh_dpc       = v;
      csr_pkg::CSR_DSCRATCH0: sh_dscratch0 = v;
      default: ;
    endcase
  endtask

  task automatic save_trap(input csr_pkg::csr_data_t pc, input csr_pkg::csr_data_t cause);
    sh_mepc       = pc;
    sh_mcause     = cause;
    sh_mstatus[7] = sh_mstatus[3];
    sh_mstatus[3] = 1'b0;
  endtask

  task automatic save_debug(input csr_pkg::csr_data_t pc);
    sh_dpc        = pc;
    sh_dcsr[8:6]  = 3'd3;
    in_debug      = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // Checks and drivers
  ////////////////////////////////////////////////////////////

  task automatic check_eq(input csr_pkg::csr_data_t got, input csr_pkg::csr_data_t exp,
                          input string what);
    assert (got == exp) else begin
      $display("MISMATCH at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    assert (got == exp) else begin
      $display("MISMATCH at %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
      errors++;
    end
  endtask

  function automatic pipe_pkg::ex_wb_pipe_t plain_instr(input csr_pkg::csr_data_t pc);
    pipe_pkg::ex_wb_pipe_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.csr_addr    = csr_pkg::CSR_MSCRATCH;
    instr.pc          = pc;
    return instr;
  endfunction

  // Present one instruction and confirm the previous one caused no redirect
  task automatic issue(input pipe_pkg::ex_wb_pipe_t instr);
    @(negedge clk);
    wb_instr  = instr;
    irq       = irq_lvl;
    debug_req = dbg_lvl;
    #1;
    check_bit(branch, 1'b0, "branch_o outside a redirect");
    check_bit(debug_mode, in_debug, "debug_mode_o");
  endtask

  task automatic csr_access(input csr_pkg::csr_op_e op, input csr_pkg::csr_num_e addr,
                            input csr_pkg::csr_data_t operand);
    pipe_pkg::ex_wb_pipe_t instr;
    csr_pkg::csr_data_t    old_val;
    csr_pkg::csr_data_t    raw;
    instr           = plain_instr(next_pc);
    instr.csr_en    = 1'b1;
    instr.csr_op    = op;
    instr.csr_addr  = addr;
    instr.csr_wdata = operand;
    issue(instr);
    old_val = shadow_read(addr);
    check_eq(csr_rdata, old_val, $sformatf("CSR %03h read", addr));
    case (op)
      csr_pkg::CSR_OP_WRITE: raw = operand;
      csr_pkg::CSR_OP_SET:   raw = old_val | operand;
      csr_pkg::CSR_OP_CLEAR: raw = old_val & ~operand;
      default:               raw = old_val;
    endcase
    if (op == csr_pkg::CSR_OP_WRITE || (op != csr_pkg::CSR_OP_READ && operand != '0)) begin
      shadow_write(addr, legalize(addr, raw));
    end
    next_pc = next_pc + 32'd4;
  endtask

  // Write-back stays empty while the redirect is pending
  task automatic wait_redirect(input csr_pkg::csr_data_t exp_addr, input string what);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      wb_instr = '0;
      #1;
      cycles++;
      seen = branch;
    end
    if (!seen) begin
      $display("Timed out at %0t ns: branch_o never rose within %0d cycles after the %s",
               $time, TIMEOUT_CYCLES, what);
      errors++;
    end else begin
      check_bit(cycles == 1, 1'b1, {"redirect timing after the ", what});
      check_eq(branch_addr, exp_addr, {"branch_addr_o after the ", what});
      check_bit(debug_mode, in_debug, "debug_mode_o in redirect cycle");
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("Test %-10s passed", name);
    end else begin
      tests_failed++;
      $display("Test %-10s failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int                    i;
    logic [3:0]            k;
    logic [1:0]            sel;
    csr_pkg::csr_num_e     addr;
    csr_pkg::csr_data_t    operand;
    csr_pkg::csr_data_t    pc;
    pipe_pkg::ex_wb_pipe_t instr;
    void'($urandom(32'h97ac5127));
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    wb_instr     = '0;
    irq          = 1'b0;
    debug_req    = 1'b0;
    irq_lvl      = 1'b0;
    dbg_lvl      = 1'b0;
    in_debug     = 1'b0;
    next_pc      = 32'h0000_2000;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    sh_mstatus   = 32'h0000_1800;
    sh_mie       = '0;
    sh_mtvec     = `CSR_MTVEC_RST;
    sh_mscratch  = '0;
    sh_mepc      = '0;
    sh_mcause    = '0;
    sh_dcsr      = {`CSR_DEBUGVER, 26'd0, `CSR_PRIV_M};
    sh_dpc       = '0;
    sh_dscratch0 = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    for (k = 4'd0; k < 4'd9; k++) begin
      csr_access(csr_pkg::CSR_OP_READ, rw_addrs[k], '0);
    end
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MIP, '0);
    // An unimplemented address reads as zero
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::csr_num_e'(12'h123), '0);
    finish_test("reset");

    for (i = 0; i < N_RANDOM; i++) begin
      k       = 4'($urandom_range(8, 0));
      addr    = rw_addrs[k];
      sel     = 2'($urandom_range(3, 0));
      operand = ($urandom_range(3, 0) == 0) ? '0 : $urandom;
      csr_access(csr_pkg::csr_op_e'(sel), addr, operand);
      csr_access(csr_pkg::CSR_OP_READ, addr, '0);
    end
    // Zero-operand set and clear on a register holding a nonzero value
    csr_access(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSCRATCH, 32'hA5C3_3C5A);
    csr_access(csr_pkg::CSR_OP_SET, csr_pkg::CSR_MSCRATCH, '0);
    csr_access(csr_pkg::CSR_OP_CLEAR, csr_pkg::CSR_MSCRATCH, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSCRATCH, '0);
    finish_test("access");

    csr_access(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    csr_access(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSCRATCH, 32'h1234_5678);
    pc              = $urandom & 32'hFFFF_FFFC;
    instr           = plain_instr(pc);
    instr.csr_en    = 1'b1;
    instr.csr_op    = csr_pkg::CSR_OP_WRITE;
    instr.csr_wdata = 32'hDEAD_BEEF;
    instr.exc       = 1'b1;
    instr.exc_code  = 5'd2;
    issue(instr);
    save_trap(pc, 32'd2);
    wait_redirect(sh_mtvec & 32'hFFFF_FFFC, "exception");
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MEPC, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MCAUSE, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSTATUS, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSCRATCH, '0);
    finish_test("exception");

    csr_access(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MIE, '0);
    csr_access(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    irq_lvl = 1'b1;
    // Pending but masked, first by mie.meie and then by mstatus.mie
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MIP, '0);
    csr_access(csr_pkg::CSR_OP_CLEAR, csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    csr_access(csr_pkg::CSR_OP_SET, csr_pkg::CSR_MIE, 32'h0000_0800);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MIP, '0);
    csr_access(csr_pkg::CSR_OP_SET, csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    pc      = next_pc;
    next_pc = next_pc + 32'd4;
    issue(plain_instr(pc));
    save_trap(pc, 32'h8000_000B);
    wait_redirect(sh_mtvec & 32'hFFFF_FFFC, "interrupt");
    irq_lvl = 1'b0;
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MCAUSE, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MEPC, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSTATUS, '0);
    instr      = plain_instr(next_pc);
    instr.mret = 1'b1;
    issue(instr);
    sh_mstatus[3] = sh_mstatus[7];
    sh_mstatus[7] = 1'b1;
    wait_redirect(sh_mepc, "mret");
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSTATUS, '0);
    finish_test("interrupt");

    dbg_lvl = 1'b1;
    pc      = next_pc;
    next_pc = next_pc + 32'd4;
    issue(plain_instr(pc));
    dbg_lvl = 1'b0;
    save_debug(pc);
    wait_redirect(`CSR_DM_HALT_ADDR, "debug request");
    // Interrupt is enabled and pending, yet debug mode must hold it off
    irq_lvl = 1'b1;
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_DPC, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_DCSR, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MIP, '0);
    irq_lvl = 1'b0;
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MCAUSE, '0);
    instr      = plain_instr(next_pc);
    instr.dret = 1'b1;
    issue(instr);
    in_debug = 1'b0;
    wait_redirect(sh_dpc, "dret");
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSTATUS, '0);
    finish_test("debug");

    dbg_lvl         = 1'b1;
    irq_lvl         = 1'b1;
    pc              = $urandom & 32'hFFFF_FFFC;
    instr           = plain_instr(pc);
    instr.csr_en    = 1'b1;
    instr.csr_op    = csr_pkg::CSR_OP_WRITE;
    instr.csr_wdata = 32'h0BAD_F00D;
    instr.exc       = 1'b1;
    instr.exc_code  = 5'd7;
    issue(instr);
    dbg_lvl = 1'b0;
    irq_lvl = 1'b0;
    save_debug(pc);
    wait_redirect(`CSR_DM_HALT_ADDR, "combined events");
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_DPC, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MEPC, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MCAUSE, '0);
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSCRATCH, '0);
    instr      = plain_instr(next_pc);
    instr.dret = 1'b1;
    issue(instr);
    in_debug = 1'b0;
    wait_redirect(sh_dpc, "dret");
    csr_access(csr_pkg::CSR_OP_READ, csr_pkg::CSR_MSTATUS, '0);
    finish_test("priority");

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
